// File: pong_gfx.f
+incdir+hdl
+incdir+tests
hdl/pong_gfx_pkg.sv
hdl/gfx_reg_file.sv
hdl/raster_scan.sv
hdl/paddle_sprite.sv
hdl/ball_sprite.sv
hdl/frame_score_sprite.sv
hdl/pixel_mixer.sv
hdl/pong_gfx_top.sv
tests/pong_gfx_tb.sv

// File: Bender.yml
package:
  name: pong_gfx

export_include_dirs:
  - hdl

sources:
  - hdl/pong_gfx_pkg.sv
  - hdl/gfx_reg_file.sv
  - hdl/raster_scan.sv
  - hdl/paddle_sprite.sv
  - hdl/ball_sprite.sv
  - hdl/frame_score_sprite.sv
  - hdl/pixel_mixer.sv
  - hdl/pong_gfx_top.sv
  - target: test
    include_dirs:
      - tests
    files:
      - tests/pong_gfx_tb.sv

// File: tests/pong_gfx_tb_tasks.svh
`ifndef PONG_GFX_TB_TASKS_SVH
`define PONG_GFX_TB_TASKS_SVH

// Galois LFSR, one step per random bit
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
	return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
endfunction

task automatic rand_bit(output logic b);
	b = lfsr[0];
	lfsr = lfsr_next(lfsr);
endtask

task automatic color_check(input string name, input rgb_t got, input rgb_t exp);
	if (got !== exp) begin
		$display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
		abort_run();
	end
endtask

task automatic addr_check(input string name, input logic [18:0] got, input logic [18:0] exp);
	if (got !== exp) begin
		$display("[FAIL] %0t %s got %0d expected %0d", $time, name, got, exp);
		abort_run();
	end
endtask

task automatic word_check(input string name, input logic [15:0] got, input logic [15:0] exp);
	if (got !== exp) begin
		$display("[FAIL] %0t %s got %h expected %h", $time, name, got, exp);
		abort_run();
	end
endtask

task automatic flag_check(input string name, input logic got, input logic exp);
	if (got !== exp) begin
		$display("[FAIL] %0t %s got %b expected %b", $time, name, got, exp);
		abort_run();
	end
endtask

// Reference register map
task automatic model_write(input reg_addr_e a, input logic [15:0] d);
	case (a)
		REG_PADDLE1_X:  model_live.paddle1.x = d;
		REG_PADDLE1_Y:  model_live.paddle1.y = d;
		REG_PADDLE2_X:  model_live.paddle2.x = d;
		REG_PADDLE2_Y:  model_live.paddle2.y = d;
		REG_BALL_X:     model_live.ball.x = d;
		REG_BALL_Y:     model_live.ball.y = d;
		REG_BALL_Z:     model_live.ball_z = d;
		REG_SCORE1:     model_live.score1 = d;
		REG_SCORE2:     model_live.score2 = d;
		REG_GAME_STATE: model_live.game_state = d;
		default: ; // Unmapped, nothing stored
	endcase
endtask

function automatic logic [15:0] model_read(input reg_addr_e a);
	case (a)
		REG_PADDLE1_X:  return model_live.paddle1.x;
		REG_PADDLE1_Y:  return model_live.paddle1.y;
		REG_PADDLE2_X:  return model_live.paddle2.x;
		REG_PADDLE2_Y:  return model_live.paddle2.y;
		REG_BALL_X:     return model_live.ball.x;
		REG_BALL_Y:     return model_live.ball.y;
		REG_BALL_Z:     return model_live.ball_z;
		REG_SCORE1:     return model_live.score1;
		REG_SCORE2:     return model_live.score2;
		REG_GAME_STATE: return model_live.game_state;
		default:        return 16'd0;
	endcase
endfunction

task automatic write_reg(input reg_addr_e a, input logic [15:0] d);
	@(posedge clk);
	cs <= 1'b1;
	read <= 1'b0;
	addr <= a;
	wr_data <= d;
	@(posedge clk);
	cs <= 1'b0;
	model_write(a, d);
endtask

// Read word shows up one cycle after the strobe
task automatic read_check(input reg_addr_e a);
	@(posedge clk);
	cs <= 1'b1;
	read <= 1'b1;
	addr <= a;
	@(posedge clk);
	cs <= 1'b0;
	read <= 1'b0;
	@(negedge clk);
	word_check("rd_data", rd_data, model_read(a));
endtask

`endif

// File: tests/pong_gfx_tb.sv
`timescale 1ns/1ps
`include "pong_gfx_defines.svh"

module pong_gfx_tb;
	import pong_gfx_pkg::*;

	localparam int FRAME = `SCREEN_W * `SCREEN_H;
	localparam int SPLIT = `SCREEN_W * 200 + 37; // Stop point inside a frame

	typedef struct packed {
		logic        valid;
		logic [18:0] addr;
		rgb_t        color;
	} exp_pix_t;

	logic        clk = 1'b0;
	logic        rst;
	logic        cs;
	logic        read;
	reg_addr_e   addr;
	logic [15:0] wr_data;
	logic [15:0] rd_data;
	logic        VGA_ready;
	rgb_t        color;
	logic [18:0] pixel_address;
	logic        pixel_valid;

	logic [31:0] lfsr = 32'hc37ed7c9;
	gfx_regs_t   model_live;
	gfx_regs_t   model_shadow; // Scene the current frame is drawn with
	int          model_addr;   // Next address the scanner accepts
	exp_pix_t    pipe [3];

	always #2 clk = ~clk;

	pong_gfx_top dut_i (
		.clk, .rst, .cs, .read, .addr, .wr_data, .rd_data,
		.VGA_ready, .color, .pixel_address, .pixel_valid
	);

	`include "pong_gfx_tb_tasks.svh"

	task automatic abort_run();
		$display("sim failed");
		$fatal(1, "Stopped at the first error");
	endtask

	function automatic logic in_box(input int x, y, input obj_pos_t loc, input int w, h);
		return x >= int'(loc.x) && x < int'(loc.x) + w && y >= int'(loc.y) && y < int'(loc.y) + h;
	endfunction

	// Block k of a row covers x0 + k*pitch for one block width
	function automatic logic in_score(input int x, y, x0, input logic [15:0] score);
		int n;
		int dx;
		n = (score > `SCORE_MAX) ? `SCORE_MAX : int'(score);
		dx = x - x0;
		if (y < `SCORE_Y0 || y >= `SCORE_Y0 + `SCORE_BLOCK || dx < 0)
			return 1'b0;
		return (dx / `SCORE_PITCH < n) && (dx % `SCORE_PITCH < `SCORE_BLOCK);
	endfunction

	function automatic rgb_t expected_color(input int x, y, input gfx_regs_t r);
		int side;
		side = `BALL_SIZE >> ((r.ball_z > 3) ? 3 : int'(r.ball_z));
		if (r.game_state[0] && in_box(x, y, r.ball, side, side))
			return `COL_BALL;
		if (in_box(x, y, r.paddle1, `PADDLE_W, `PADDLE_H))
			return `COL_PADDLE1;
		if (in_box(x, y, r.paddle2, `PADDLE_W, `PADDLE_H))
			return `COL_PADDLE2;
		if (x < `BORDER || y < `BORDER || x >= `SCREEN_W - `BORDER || y >= `SCREEN_H - `BORDER)
			return `COL_FRAME;
		if (in_score(x, y, `SCORE1_X0, r.score1) || in_score(x, y, `SCORE2_X0, r.score2))
			return `COL_SCORE;
		return `COL_BG;
	endfunction

	// One pixel clock, checking the output due from two cycles back
	task automatic clock_pixel(input logic go);
		@(posedge clk);
		VGA_ready <= go;
		pipe[2] = pipe[1];
		pipe[1] = pipe[0];
		pipe[0] = '0;
		if (go) begin
			pipe[0] = '{1'b1, 19'(model_addr),
				expected_color(model_addr % `SCREEN_W, model_addr / `SCREEN_W, model_shadow)};
			if (model_addr == `PIXEL_LAST)
				model_shadow = model_live; // Frame boundary
			model_addr = (model_addr == `PIXEL_LAST) ? 0 : model_addr + 1;
		end
		@(negedge clk);
		flag_check("pixel_valid", pixel_valid, pipe[2].valid);
		if (pipe[2].valid) begin
			addr_check("pixel_address", pixel_address, pipe[2].addr);
			color_check("color", color, pipe[2].color);
		end
	endtask

	task automatic stream_pixels(input int count);
		int accepted;
		int cycles;
		logic b0;
		logic b1;
		accepted = 0;
		cycles = 0;
		while (accepted < count) begin
			if (cycles > 2 * count + 100) begin
				$display("Timed out before %0d pixels were accepted", count);
				abort_run();
			end
			rand_bit(b0);
			rand_bit(b1);
			clock_pixel(b0 | b1); // Roughly one gap in four
			accepted += int'(b0 | b1);
			cycles++;
		end
		clock_pixel(1'b0); // Drain the two pipeline stages
		clock_pixel(1'b0);
	endtask

	task automatic stream_to_frame_end();
		stream_pixels(FRAME - model_addr);
	endtask

	task automatic set_scene(input int p1x, p1y, p2x, p2y, bx, by, bz, gs);
		write_reg(REG_PADDLE1_X, 16'(p1x));
		write_reg(REG_PADDLE1_Y, 16'(p1y));
		write_reg(REG_PADDLE2_X, 16'(p2x));
		write_reg(REG_PADDLE2_Y, 16'(p2y));
		write_reg(REG_BALL_X, 16'(bx));
		write_reg(REG_BALL_Y, 16'(by));
		write_reg(REG_BALL_Z, 16'(bz));
		write_reg(REG_GAME_STATE, 16'(gs));
	endtask

	task automatic register_access();
		logic [15:0] held;
		for (int i = 0; i < 16; i++)
			read_check(reg_addr_e'(4'(i)));
		for (int i = 0; i < 10; i++)
			write_reg(reg_addr_e'(4'(i)), 16'h1357 ^ 16'(i * 16'h0911));
		for (int i = 10; i < 16; i++)
			write_reg(reg_addr_e'(4'(i)), 16'hbeef); // Unmapped
		for (int i = 0; i < 16; i++)
			read_check(reg_addr_e'(4'(i)));
		read_check(REG_BALL_X);
		held = model_read(REG_BALL_X);
		set_scene(`RST_PADDLE1_X, `RST_PADDLE1_Y, `RST_PADDLE2_X, `RST_PADDLE2_Y,
			`RST_BALL_X, `RST_BALL_Y, `RST_BALL_Z, `RST_GAME_STATE);
		write_reg(REG_SCORE1, `RST_SCORE);
		write_reg(REG_SCORE2, `RST_SCORE);
		@(negedge clk);
		word_check("rd_data", rd_data, held); // Writes leave the read word alone
	endtask

	// First part of frame 0, reset scene
	task automatic reset_frame_scan();
		stream_pixels(SPLIT);
	endtask

	task automatic score_rows();
		write_reg(REG_SCORE1, 16'd3);
		write_reg(REG_SCORE2, 16'd12); // Saturates at eight blocks
		stream_to_frame_end();
		stream_pixels(SPLIT);
	endtask

	task automatic mid_frame_move();
		set_scene(24, 100, 600, 120, 100, 50, 0, 1);
		stream_to_frame_end(); // Old positions until the boundary
		stream_pixels(SPLIT);
	endtask

	task automatic ball_depth_priority();
		set_scene(24, 100, 600, 120, 26, 110, 0, 1); // Ball on paddle 1
		stream_to_frame_end();
		set_scene(24, 100, 600, 120, 0, 60, 1, 1); // Ball on left border
		stream_to_frame_end();
		set_scene(24, 100, 600, 120, 602, 130, 2, 1); // Ball on paddle 2
		stream_to_frame_end();
		set_scene(24, 100, 600, 120, 20, 8, 3, 1); // Ball on a score block
		stream_to_frame_end();
		set_scene(24, 100, 600, 120, 632, 472, 9, 1); // Depth clips to 3
		stream_to_frame_end();
		set_scene(24, 100, 28, 120, 26, 110, 0, 0); // Hidden ball, paddles overlap
		stream_to_frame_end();
		stream_to_frame_end();
	endtask

	initial begin
		rst = 1'b1;
		cs = 1'b0;
		read = 1'b0;
		addr = REG_PADDLE1_X;
		wr_data = 16'd0;
		VGA_ready = 1'b0;
		model_live = '{'{`RST_PADDLE1_X, `RST_PADDLE1_Y}, '{`RST_PADDLE2_X, `RST_PADDLE2_Y},
			'{`RST_BALL_X, `RST_BALL_Y}, `RST_BALL_Z, `RST_SCORE, `RST_SCORE, `RST_GAME_STATE};
		model_shadow = model_live;
		model_addr = 0;
		foreach (pipe[i])
			pipe[i] = '0;
		repeat (16) @(posedge clk);
		rst <= 1'b0;
		@(negedge clk);
		flag_check("pixel_valid", pixel_valid, 1'b0);
		word_check("rd_data", rd_data, 16'd0);
		register_access();
		reset_frame_scan();
		score_rows();
		mid_frame_move();
		ball_depth_priority();
		$display("sim passed");
		$finish;
	end

endmodule

// File: hdl/pong_gfx_top.sv
`timescale 1ns/1ps

module pong_gfx_top (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     cs,
	input  logic                     read,
	input  pong_gfx_pkg::reg_addr_e  addr,
	input  logic [15:0]              wr_data,
	output logic [15:0]              rd_data,
	input  logic                     VGA_ready,
	output pong_gfx_pkg::rgb_t       color,
	output logic [18:0]              pixel_address,
	output logic                     pixel_valid
);
	import pong_gfx_pkg::*;

	gfx_regs_t  shadow;
	pix_stage_t stage0;
	pix_stage_t stage1;
	logic       frame_end;
	logic       paddle1_hit;
	logic       paddle2_hit;
	logic       ball_hit;
	logic       fs_hit;
	rgb_t       fs_color;

	gfx_reg_file regs_i (
		.clk, .rst, .cs, .read, .addr, .wr_data,
		.frame_end, .rd_data, .shadow
	);

	raster_scan scan_i (.clk, .rst, .VGA_ready, .stage(stage0), .frame_end);

	paddle_sprite paddle1_i (.clk, .rst, .pos(stage0.pos), .loc(shadow.paddle1), .hit(paddle1_hit));
	paddle_sprite paddle2_i (.clk, .rst, .pos(stage0.pos), .loc(shadow.paddle2), .hit(paddle2_hit));

	ball_sprite ball_i (
		.clk, .rst, .pos(stage0.pos), .loc(shadow.ball),
		.depth(shadow.ball_z), .show(shadow.game_state[0]), .hit(ball_hit)
	);

	frame_score_sprite fs_i (
		.clk, .rst, .pos(stage0.pos), .score1(shadow.score1),
		.score2(shadow.score2), .hit(fs_hit), .color(fs_color)
	);

	// Stage 1 runs beside the renderer hit registers
	always_ff @(posedge clk) begin
		if (rst)
			stage1 <= '0;
		else
			stage1 <= stage0;
	end

	pixel_mixer mixer_i (
		.clk, .rst, .stage(stage1), .ball_hit, .paddle1_hit, .paddle2_hit,
		.fs_hit, .fs_color, .color, .pixel_address, .pixel_valid
	);

endmodule

// File: hdl/pixel_mixer.sv
`timescale 1ns/1ps
`include "pong_gfx_defines.svh"

module pixel_mixer (
	input  logic                      clk,
	input  logic                      rst,
	input  pong_gfx_pkg::pix_stage_t  stage,
	input  logic                      ball_hit,
	input  logic                      paddle1_hit,
	input  logic                      paddle2_hit,
	input  logic                      fs_hit,
	input  pong_gfx_pkg::rgb_t        fs_color,
	output pong_gfx_pkg::rgb_t        color,
	output logic [18:0]               pixel_address,
	output logic                      pixel_valid
);
	import pong_gfx_pkg::*;

	rgb_t mix;

	// Fixed priority, ball on top
	always_comb begin
		if (ball_hit)
			mix = `COL_BALL;
		else if (paddle1_hit)
			mix = `COL_PADDLE1;
		else if (paddle2_hit)
			mix = `COL_PADDLE2;
		else if (fs_hit)
			mix = fs_color;
		else
			mix = `COL_BG;
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			pixel_valid   <= 1'b0;
			pixel_address <= 19'd0;
		end else begin
			pixel_valid   <= stage.valid;
			pixel_address <= stage.addr;
		end
	end

	always_ff @(posedge clk)
		color <= mix;

	a_addr_in_frame: assert property (@(posedge clk) disable iff (rst)
		pixel_valid |-> (pixel_address <= 19'(`PIXEL_LAST)))
		else $error("pixel_address beyond the last pixel");

endmodule

// File: hdl/frame_score_sprite.sv
`timescale 1ns/1ps
`include "pong_gfx_defines.svh"

module frame_score_sprite (
	input  logic                      clk,
	input  logic                      rst,
	input  pong_gfx_pkg::pixel_pos_t  pos,
	input  logic [15:0]               score1,
	input  logic [15:0]               score2,
	output logic                      hit,
	output pong_gfx_pkg::rgb_t        color
);
	import pong_gfx_pkg::*;

	logic [3:0] count1;
	logic [3:0] count2;
	logic       on_border;
	logic       in_row;
	logic       on_score;

	// True when x falls in one of the first count blocks of a row
	function automatic logic row_hit(input logic [15:0] x, input logic [15:0] x0,
			input logic [3:0] count);
		logic found;
		logic [15:0] bx;
		found = 1'b0;
		for (int k = 0; k < `SCORE_MAX; k++) begin
			bx = x0 + 16'(k * `SCORE_PITCH);
			if ((k < count) && (x >= bx) && (x < bx + 16'(`SCORE_BLOCK)))
				found = 1'b1;
		end
		return found;
	endfunction

	assign count1 = (score1 > 16'(`SCORE_MAX)) ? 4'(`SCORE_MAX) : score1[3:0];
	assign count2 = (score2 > 16'(`SCORE_MAX)) ? 4'(`SCORE_MAX) : score2[3:0];

	assign on_border = (pos.x < 16'(`BORDER)) || (pos.x >= 16'(`SCREEN_W - `BORDER)) ||
		(pos.y < 16'(`BORDER)) || (pos.y >= 16'(`SCREEN_H - `BORDER));

	assign in_row = (pos.y >= 16'(`SCORE_Y0)) &&
		(pos.y < 16'(`SCORE_Y0 + `SCORE_BLOCK));

	assign on_score = in_row && (row_hit(pos.x, 16'(`SCORE1_X0), count1) ||
		row_hit(pos.x, 16'(`SCORE2_X0), count2));

	always_ff @(posedge clk) begin
		if (rst) begin
			hit   <= 1'b0;
			color <= `COL_BG;
		end else begin
			hit <= on_border || on_score;
			if (on_border)
				color <= `COL_FRAME; // Border wins over score
			else if (on_score)
				color <= `COL_SCORE;
			else
				color <= `COL_BG;
		end
	end

endmodule

// File: hdl/ball_sprite.sv
`timescale 1ns/1ps
`include "pong_gfx_defines.svh"

module ball_sprite (
	input  logic                      clk,
	input  logic                      rst,
	input  pong_gfx_pkg::pixel_pos_t  pos,
	input  pong_gfx_pkg::obj_pos_t    loc,
	input  logic [15:0]               depth,
	input  logic                      show,
	output logic                      hit
);

	logic [1:0]  shift;
	logic [4:0]  side;
	logic [15:0] dx;
	logic [15:0] dy;
	logic        in_x;
	logic        in_y;

	// Farther ball is drawn smaller, depth saturates at 3
	assign shift = (depth > 16'd3) ? 2'd3 : depth[1:0];
	assign side  = 5'(`BALL_SIZE) >> shift; // 16, 8, 4 or 2

	assign dx = pos.x - loc.x;
	assign dy = pos.y - loc.y;

	assign in_x = (pos.x >= loc.x) && (dx < 16'(side));
	assign in_y = (pos.y >= loc.y) && (dy < 16'(side));

	always_ff @(posedge clk) begin
		if (rst)
			hit <= 1'b0;
		else
			hit <= show && in_x && in_y;
	end

endmodule

// File: hdl/paddle_sprite.sv
`timescale 1ns/1ps
`include "pong_gfx_defines.svh"

module paddle_sprite (
	input  logic                      clk,
	input  logic                      rst,
	input  pong_gfx_pkg::pixel_pos_t  pos,
	input  pong_gfx_pkg::obj_pos_t    loc,
	output logic                      hit
);

	logic [15:0] dx;
	logic [15:0] dy;
	logic        in_x;
	logic        in_y;

	// Offsets are only meaningful once pos is past the corner
	assign dx = pos.x - loc.x;
	assign dy = pos.y - loc.y;

	assign in_x = (pos.x >= loc.x) && (dx < 16'(`PADDLE_W));
	assign in_y = (pos.y >= loc.y) && (dy < 16'(`PADDLE_H));

	always_ff @(posedge clk) begin
		if (rst)
			hit <= 1'b0;
		else
			hit <= in_x && in_y;
	end

endmodule

// File: hdl/raster_scan.sv
`timescale 1ns/1ps
`include "pong_gfx_defines.svh"

module raster_scan (
	input  logic                      clk,
	input  logic                      rst,
	input  logic                      VGA_ready,
	output pong_gfx_pkg::pix_stage_t  stage,
	output logic                      frame_end
);

	logic [15:0] x;
	logic [15:0] y;
	logic [18:0] addr;

	assign stage.valid = VGA_ready;
	assign stage.pos.x = x;
	assign stage.pos.y = y;
	assign stage.addr  = addr;

	assign frame_end = VGA_ready && (addr == 19'(`PIXEL_LAST));

	always_ff @(posedge clk) begin
		if (rst) begin
			x    <= 16'd0;
			y    <= 16'd0;
			addr <= 19'd0;
		end else if (VGA_ready) begin
			if (x == 16'(`SCREEN_W - 1)) begin
				x <= 16'd0;
				// Row wrap, then frame wrap
				if (y == 16'(`SCREEN_H - 1))
					y <= 16'd0;
				else
					y <= y + 16'd1;
			end else begin
				x <= x + 16'd1;
			end
			addr <= frame_end ? 19'd0 : addr + 19'd1;
		end
	end

	a_pos_in_screen: assert property (@(posedge clk) disable iff (rst)
		(x < 16'(`SCREEN_W)) && (y < 16'(`SCREEN_H)))
		else $error("scan position left the screen");

endmodule

// File: hdl/gfx_reg_file.sv
`timescale 1ns/1ps
`include "pong_gfx_defines.svh"

module gfx_reg_file (
	input  logic                     clk,
	input  logic                     rst,
	input  logic                     cs,
	input  logic                     read,
	input  pong_gfx_pkg::reg_addr_e  addr,
	input  logic [15:0]              wr_data,
	input  logic                     frame_end,
	output logic [15:0]              rd_data,
	output pong_gfx_pkg::gfx_regs_t  shadow
);
	import pong_gfx_pkg::*;

	localparam gfx_regs_t REGS_RESET = '{
		paddle1:    '{x: `RST_PADDLE1_X, y: `RST_PADDLE1_Y},
		paddle2:    '{x: `RST_PADDLE2_X, y: `RST_PADDLE2_Y},
		ball:       '{x: `RST_BALL_X, y: `RST_BALL_Y},
		ball_z:     `RST_BALL_Z,
		score1:     `RST_SCORE,
		score2:     `RST_SCORE,
		game_state: `RST_GAME_STATE
	};

	gfx_regs_t   live;
	gfx_regs_t   live_next;
	logic [15:0] rd_word;

	// Write decode, unmapped addresses fall through
	always_comb begin
		live_next = live;
		if (cs && !read) begin
			case (addr)
				REG_PADDLE1_X:  live_next.paddle1.x = wr_data;
				REG_PADDLE1_Y:  live_next.paddle1.y = wr_data;
				REG_PADDLE2_X:  live_next.paddle2.x = wr_data;
				REG_PADDLE2_Y:  live_next.paddle2.y = wr_data;
				REG_BALL_X:     live_next.ball.x = wr_data;
				REG_BALL_Y:     live_next.ball.y = wr_data;
				REG_BALL_Z:     live_next.ball_z = wr_data;
				REG_SCORE1:     live_next.score1 = wr_data;
				REG_SCORE2:     live_next.score2 = wr_data;
				REG_GAME_STATE: live_next.game_state = wr_data;
				default: ;
			endcase
		end
	end

	always_comb begin
		case (addr)
			REG_PADDLE1_X:  rd_word = live.paddle1.x;
			REG_PADDLE1_Y:  rd_word = live.paddle1.y;
			REG_PADDLE2_X:  rd_word = live.paddle2.x;
			REG_PADDLE2_Y:  rd_word = live.paddle2.y;
			REG_BALL_X:     rd_word = live.ball.x;
			REG_BALL_Y:     rd_word = live.ball.y;
			REG_BALL_Z:     rd_word = live.ball_z;
			REG_SCORE1:     rd_word = live.score1;
			REG_SCORE2:     rd_word = live.score2;
			REG_GAME_STATE: rd_word = live.game_state;
			default:        rd_word = 16'd0;
		endcase
	end

	always_ff @(posedge clk) begin
		if (rst) begin
			live    <= REGS_RESET;
			shadow  <= REGS_RESET;
			rd_data <= 16'd0;
		end else begin
			live <= live_next;
			if (frame_end)
				shadow <= live_next; // Same-cycle write lands in the new frame
			if (cs && read)
				rd_data <= rd_word; // Holds between reads
		end
	end

	// Scene only moves at a frame boundary
	a_shadow_frozen: assert property (@(posedge clk) disable iff (rst)
		!frame_end |=> $stable(shadow))
		else $error("shadow registers changed outside frame_end");

endmodule

// File: hdl/pong_gfx_pkg.sv
package pong_gfx_pkg;

	typedef struct packed {
		logic [7:0] r;
		logic [7:0] g;
		logic [7:0] b;
	} rgb_t;

	// Current scan position
	typedef struct packed {
		logic [15:0] x;
		logic [15:0] y;
	} pixel_pos_t;

	// Top-left corner of an object
	typedef struct packed {
		logic [15:0] x;
		logic [15:0] y;
	} obj_pos_t;

	typedef struct packed {
		obj_pos_t    paddle1;
		obj_pos_t    paddle2;
		obj_pos_t    ball;
		logic [15:0] ball_z;
		logic [15:0] score1;
		logic [15:0] score2;
		logic [15:0] game_state; // Bit 0 shows the ball
	} gfx_regs_t;

	// One pixel moving down the pipeline
	typedef struct packed {
		logic        valid;
		pixel_pos_t  pos;
		logic [18:0] addr;
	} pix_stage_t;

	typedef enum logic [3:0] {
		REG_PADDLE1_X  = 4'd0,
		REG_PADDLE1_Y  = 4'd1,
		REG_PADDLE2_X  = 4'd2,
		REG_PADDLE2_Y  = 4'd3,
		REG_BALL_X     = 4'd4,
		REG_BALL_Y     = 4'd5,
		REG_BALL_Z     = 4'd6,
		REG_SCORE1     = 4'd7,
		REG_SCORE2     = 4'd8,
		REG_GAME_STATE = 4'd9
	} reg_addr_e;

endpackage

// File: hdl/pong_gfx_defines.svh
`ifndef PONG_GFX_DEFINES_SVH
`define PONG_GFX_DEFINES_SVH

// Screen geometry
`define SCREEN_W 640
`define SCREEN_H 480
`define PIXEL_LAST 307199

// Object sizes
`define PADDLE_W 8
`define PADDLE_H 48
`define BALL_SIZE 16 // Side at depth 0
`define BORDER 4

// Score block rows
`define SCORE_BLOCK 8
`define SCORE_PITCH 12
`define SCORE_MAX 8
`define SCORE1_X0 16
`define SCORE2_X0 528
`define SCORE_Y0 8

// Colours as 24-bit RGB
`define COL_PADDLE1 24'h2080FF
`define COL_PADDLE2 24'hFF4020
`define COL_BALL 24'hFFFFFF
`define COL_FRAME 24'h808080
`define COL_SCORE 24'hFFD000
`define COL_BG 24'h000000

// Register values after reset
`define RST_PADDLE1_X 16'd320
`define RST_PADDLE1_Y 16'd200
`define RST_PADDLE2_X 16'd350
`define RST_PADDLE2_Y 16'd250
`define RST_BALL_X 16'd320
`define RST_BALL_Y 16'd240
`define RST_BALL_Z 16'd0
`define RST_SCORE 16'd0
`define RST_GAME_STATE 16'd0

`endif
